/* hw/xlat_pkg.sv */
// widths, derived constants and command structs for the bus translator
`default_nettype none

package xlat_pkg;

   // ------------------------------------------------------------------------
   // widths
   // ------------------------------------------------------------------------
   localparam int bytes_per_word = 4;
   localparam int word_shift     = $clog2(bytes_per_word); // byte to word
   localparam int uav_addr_w     = 32;
   localparam int av_addr_w      = uav_addr_w - word_shift;
   localparam int data_w         = 32;
   localparam int uav_burst_w    = 6;                      // burst count in bytes
   localparam int av_burst_w     = uav_burst_w - word_shift;

   // universal side command held by the master while stalled
   typedef struct packed {
      logic                      read;
      logic                      write;
      logic [uav_addr_w-1:0]     address;
      logic [uav_burst_w-1:0]    burstcount;
      logic [bytes_per_word-1:0] byteenable;
      logic [data_w-1:0]         writedata;
   } uav_cmd_t;

   // target side command stream
   typedef struct packed {
      logic                      read;
      logic                      write;
      logic [av_addr_w-1:0]      address;    // word address
      logic [av_burst_w-1:0]     burstcount; // in words
      logic [bytes_per_word-1:0] byteenable;
      logic [bytes_per_word-1:0] writebyteenable;
      logic [data_w-1:0]         writedata;
      logic                      begintransfer;
      logic                      beginbursttransfer;
      logic                      chipselect;
   } av_cmd_t;

endpackage

`default_nettype wire

/* hw/wait_state_timer.sv */
// wait-state counter producing waitrequest and the shaped read and write strobes
`timescale 1ns/1ps
`default_nettype none

module wait_state_timer #(
   parameter int setup_cycles      = 1,
   parameter int read_wait_cycles  = 1,
   parameter int write_wait_cycles = 1,
   parameter int hold_cycles       = 1
) (
   input  wire  clk,
   input  wire  reset,
   input  logic read,
   input  logic write,
   output logic waitrequest,
   output logic read_strobe,
   output logic write_strobe
);

   // counter value at which each command is released
   localparam int read_total  = setup_cycles + read_wait_cycles;
   localparam int write_total = setup_cycles + write_wait_cycles + hold_cycles;
   localparam int max_total   = (read_total > write_total) ? read_total : write_total;
   localparam int cnt_w       = (max_total > 0) ? $clog2(max_total + 1) : 1;

   localparam logic [cnt_w-1:0] setup_last = cnt_w'(setup_cycles);
   localparam logic [cnt_w-1:0] wdata_last = cnt_w'(setup_cycles + write_wait_cycles);
   localparam logic [cnt_w-1:0] read_last  = cnt_w'(read_total);
   localparam logic [cnt_w-1:0] write_last = cnt_w'(write_total);

   logic [cnt_w-1:0] wait_cnt;
   logic             reset_override; // first cycle out of reset
   logic             wait_read;
   logic             wait_write;

   // ------------------------------------------------------------------------
   // wait-latency counter
   // ------------------------------------------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         wait_cnt       <= '0;
         reset_override <= 1'b1;
      end else begin
         reset_override <= 1'b0;
         if (!waitrequest || reset_override) begin
            wait_cnt <= '0;                   // accepted or just out of reset
         end else if (read || write) begin
            wait_cnt <= wait_cnt + 1'b1;
         end else begin
            wait_cnt <= '0;
         end
      end
   end

   // ------------------------------------------------------------------------
   // waitrequest and strobe windows
   // ------------------------------------------------------------------------
   always_comb begin
      wait_read  = (wait_cnt != read_last);
      wait_write = (wait_cnt != write_last);

      // write includes the data-hold cycles
      if (write) begin
         waitrequest = wait_write | reset_override;
      end else begin
         waitrequest = wait_read | reset_override;
      end

      read_strobe  = (wait_cnt >= setup_last);
      write_strobe = (wait_cnt >= setup_last) && (wait_cnt <= wdata_last);
   end

endmodule

`default_nettype wire

/* hw/read_latency_pipe.sv */
// fixed read-latency shift register for readdatavalid and chipselect extension
`timescale 1ns/1ps
`default_nettype none

module read_latency_pipe #(
   parameter int read_latency = 1
) (
   input  wire  clk,
   input  wire  reset,
   input  logic read,
   input  logic waitrequest,
   output logic readdatavalid,
   output logic cs_extend
);

   logic [read_latency-1:0] lat_sr;   // one bit per read in flight
   logic                    read_q;   // read seen last cycle
   logic                    accept;
   logic                    pending;  // read not yet at the top stage

   assign accept = read & ~waitrequest;

   // ------------------------------------------------------------------------
   // shift register with the data strobe as its top bit
   // ------------------------------------------------------------------------
   generate
      if (read_latency > 1) begin : g_multi
         always_ff @(posedge clk or posedge reset) begin
            if (reset) begin
               lat_sr <= '0;
            end else begin
               lat_sr <= {lat_sr[read_latency-2:0], accept};
            end
         end
         assign pending = |lat_sr[read_latency-2:0];
      end else begin : g_single
         always_ff @(posedge clk or posedge reset) begin
            if (reset) begin
               lat_sr <= '0;
            end else begin
               lat_sr <= accept;
            end
         end
         assign pending = 1'b0;  // no stage below the top
      end
   endgenerate

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         read_q <= 1'b0;
      end else begin
         read_q <= read;
      end
   end

   assign readdatavalid = lat_sr[read_latency-1];
   assign cs_extend     = read_q | pending;

endmodule

`default_nettype wire

/* hw/transfer_markers.sv */
// begintransfer and beginbursttransfer generation for the target side
`timescale 1ns/1ps
`default_nettype none

module transfer_markers import xlat_pkg::*; (
   input  wire      clk,
   input  wire      reset,
   input  uav_cmd_t cmd,
   input  logic     waitrequest,
   output logic     begintransfer,
   output logic     beginbursttransfer
);

   localparam logic [uav_burst_w-1:0] last_beat = uav_burst_w'(bytes_per_word);

   logic end_begintransfer;      // command already marked and still stalled
   logic end_beginbursttransfer; // previous cycle was a non-final write beat
   logic in_burst;
   logic cmd_valid;
   logic final_beat;

   assign cmd_valid  = cmd.read | cmd.write;
   assign final_beat = (cmd.burstcount == last_beat);

   // ------------------------------------------------------------------------
   // begintransfer on the first cycle of each command only
   // ------------------------------------------------------------------------
   assign begintransfer = cmd_valid & ~end_begintransfer;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         end_begintransfer <= 1'b0;
      end else if (begintransfer && waitrequest) begin
         end_begintransfer <= 1'b1;
      end else if (!waitrequest) begin
         end_begintransfer <= 1'b0;   // accepted so the next command starts fresh
      end
   end

   // ------------------------------------------------------------------------
   // beginbursttransfer on every read and on the first write beat
   // ------------------------------------------------------------------------
   assign beginbursttransfer = cmd.read ? begintransfer
                             : (begintransfer & ~end_beginbursttransfer & ~in_burst);

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         end_beginbursttransfer <= 1'b0;
         in_burst               <= 1'b0;
      end else begin
         end_beginbursttransfer <= cmd.write & ~final_beat;
         if (cmd.write && final_beat) begin
            in_burst <= 1'b0;         // burst closes with this beat
         end else if (cmd.write) begin
            in_burst <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

/* hw/command_mapper.sv */
// byte to word conversion and assembly of the target command
`timescale 1ns/1ps
`default_nettype none

module command_mapper import xlat_pkg::*; (
   input  uav_cmd_t cmd,
   input  logic     read_strobe,
   input  logic     write_strobe,
   input  logic     begintransfer,
   input  logic     beginbursttransfer,
   input  logic     cs_extend,
   output av_cmd_t  av
);

   logic av_write;

   // gated write that also masks the write byte lanes
   assign av_write = cmd.write & write_strobe;

   always_comb begin
      // ---------------------------------------------------------------------
      // strobes shaped by the wait-state window
      // ---------------------------------------------------------------------
      av.read  = cmd.read & read_strobe;
      av.write = av_write;

      // ---------------------------------------------------------------------
      // byte address and byte burst count to words
      // ---------------------------------------------------------------------
      av.address    = cmd.address[uav_addr_w-1:word_shift];
      av.burstcount = cmd.burstcount[uav_burst_w-1:word_shift];

      av.byteenable      = cmd.byteenable;
      av.writebyteenable = cmd.byteenable & {bytes_per_word{av_write}};
      av.writedata       = cmd.writedata;

      av.begintransfer      = begintransfer;
      av.beginbursttransfer = beginbursttransfer;

      // held over the whole command and through read latency
      av.chipselect = cmd.read | cmd.write | cs_extend;
   end

endmodule

`default_nettype wire

/* hw/slave_translator.sv */
// top level of the fixed-timing bus translator
`timescale 1ns/1ps
`default_nettype none

module slave_translator import xlat_pkg::*; #(
   parameter int setup_cycles      = 1,
   parameter int read_wait_cycles  = 1,
   parameter int write_wait_cycles = 1,
   parameter int hold_cycles       = 1,
   parameter int read_latency      = 1
) (
   input  wire               clk,
   input  wire               reset,
   input  uav_cmd_t          uav,
   output logic              waitrequest,
   output logic [data_w-1:0] readdata,
   output logic              readdatavalid,
   output av_cmd_t           av,
   input  logic [data_w-1:0] av_readdata
);

   logic read_strobe;
   logic write_strobe;
   logic cs_extend;
   logic begintransfer;
   logic beginbursttransfer;

   wait_state_timer #(
      .setup_cycles      (setup_cycles),
      .read_wait_cycles  (read_wait_cycles),
      .write_wait_cycles (write_wait_cycles),
      .hold_cycles       (hold_cycles)
   ) u_wait_state_timer (
      .clk          (clk),
      .reset        (reset),
      .read         (uav.read),
      .write        (uav.write),
      .waitrequest  (waitrequest),
      .read_strobe  (read_strobe),
      .write_strobe (write_strobe)
   );

   read_latency_pipe #(
      .read_latency (read_latency)
   ) u_read_latency_pipe (
      .clk           (clk),
      .reset         (reset),
      .read          (uav.read),
      .waitrequest   (waitrequest),
      .readdatavalid (readdatavalid),
      .cs_extend     (cs_extend)
   );

   transfer_markers u_transfer_markers (
      .clk                (clk),
      .reset              (reset),
      .cmd                (uav),
      .waitrequest        (waitrequest),
      .begintransfer      (begintransfer),
      .beginbursttransfer (beginbursttransfer)
   );

   command_mapper u_command_mapper (
      .cmd                (uav),
      .read_strobe        (read_strobe),
      .write_strobe       (write_strobe),
      .begintransfer      (begintransfer),
      .beginbursttransfer (beginbursttransfer),
      .cs_extend          (cs_extend),
      .av                 (av)
   );

   assign readdata = av_readdata;  // target data lines up with readdatavalid

endmodule

`default_nettype wire

/* sim/target_model.sv */
// behavioral fixed-latency word memory acting as the target
`timescale 1ns/1ps
`default_nettype none

module target_model import xlat_pkg::*; #(
   parameter int read_latency = 2,
   parameter int depth_words  = 256
) (
   input  wire               clk,
   input  av_cmd_t           av,
   output logic [data_w-1:0] readdata
);

   localparam int idx_w = $clog2(depth_words);

   logic [data_w-1:0] mem  [depth_words];
   logic [data_w-1:0] pipe [read_latency];   // read data in flight
   logic [idx_w-1:0]  idx;

   assign idx = av.address[idx_w-1:0];

   initial begin
      for (int i = 0; i < depth_words; i++) begin
         mem[i] = '0;                         // memory starts cleared
      end
      for (int i = 0; i < read_latency; i++) begin
         pipe[i] = '0;
      end
   end

   // byte lane writes and the fixed read pipe
   always @(posedge clk) begin
      if (av.write && av.chipselect) begin
         for (int b = 0; b < bytes_per_word; b++) begin
            if (av.writebyteenable[b]) begin
               mem[idx][8*b +: 8] <= av.writedata[8*b +: 8];
            end
         end
      end
      pipe[0] <= av.read ? mem[idx] : '0;    // sampled on every read cycle
      for (int i = 1; i < read_latency; i++) begin
         pipe[i] <= pipe[i-1];
      end
   end

   assign readdata = pipe[read_latency-1];

endmodule

`default_nettype wire

/* sim/tb_slave_translator.sv */
// testbench for the bus translator with case player, bus monitor and watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_slave_translator import xlat_pkg::*; ();

   localparam int cycles_per_case = 40;
   localparam int accept_cycle    = 4;   // setup 1 + wait 2, or setup 1 + wait 1 + hold 1
   localparam int strobe_first    = 2;   // first cycle after the setup cycle
   localparam int wdata_cycle     = 3;   // last write cycle before the hold cycle
   localparam int rd_latency      = 2;

   logic              clk;
   logic              reset;
   uav_cmd_t          uav;
   logic              waitrequest;
   logic              readdatavalid;
   logic [data_w-1:0] readdata;
   logic [data_w-1:0] av_readdata;
   av_cmd_t           av;

   // case table
   string       case_name[$];
   string       case_op[$];
   logic [31:0] case_addr[$];
   int          case_beats[$];
   logic [31:0] case_data[$];
   logic [3:0]  case_be[$];
   logic [31:0] case_exp[$];

   logic [31:0] mirror [int];           // expected memory contents by word
   int          due_q[$];               // cycle where each read returns
   logic [31:0] exp_q[$];
   logic [31:0] rd_expect;
   logic        rd_prev;                // read present in the previous cycle
   logic        cs_expect;
   string       cur_name = "reset";
   int          ncases = 0;
   int          cyc = 0;
   int          bt_cnt, bbt_cnt, case_errs, errors, passed, failed;

   slave_translator #(
      .setup_cycles      (1),
      .read_wait_cycles  (2),
      .write_wait_cycles (1),
      .hold_cycles       (1),
      .read_latency      (rd_latency)
   ) u_slave_translator (
      .clk           (clk),
      .reset         (reset),
      .uav           (uav),
      .waitrequest   (waitrequest),
      .readdata      (readdata),
      .readdatavalid (readdatavalid),
      .av            (av),
      .av_readdata   (av_readdata)
   );

   target_model #(.read_latency(rd_latency)) u_target_model (
      .clk      (clk),
      .av       (av),
      .readdata (av_readdata)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   task automatic flag_value(input string what, input logic [31:0] exp, input logic [31:0] act);
      $display("error %s %s expected %h actual %h", cur_name, what, exp, act);
      case_errs++;
   endtask

   function automatic logic [31:0] merge_bytes(logic [31:0] old, logic [31:0] data,
                                               logic [3:0] be);
      logic [31:0] res;
      res = old;
      for (int b = 0; b < 4; b++) begin
         if (be[b]) res[8*b +: 8] = data[8*b +: 8];
      end
      return res;
   endfunction

   function automatic logic [31:0] mirror_word(int w);
      if (mirror.exists(w)) return mirror[w];
      return '0;
   endfunction

   // --------------------------------------------------------------------------
   // bus monitor sampling mid-cycle
   // --------------------------------------------------------------------------
   always @(negedge clk) begin
      if (!reset) begin
         cyc++;
         if (av.begintransfer) bt_cnt++;
         if (av.beginbursttransfer) bbt_cnt++;
         if (!av.write && av.writebyteenable != '0) begin
            flag_value("idle writebyteenable", 32'h0, 32'(av.writebyteenable));
         end
         if (av.write) begin
            if (av.writebyteenable != uav.byteenable)
               flag_value("writebyteenable", 32'(uav.byteenable), 32'(av.writebyteenable));
            if (av.address != uav.address[31:2])
               flag_value("word address", 32'(uav.address[31:2]), 32'(av.address));
         end
         if (readdatavalid) begin
            if (due_q.size() == 0) begin
               $display("error %s readdatavalid seen with no read in flight", cur_name);
               case_errs++;
            end else begin
               if (cyc != due_q[0]) flag_value("readdatavalid cycle", due_q[0], cyc);
               if (readdata != exp_q[0]) flag_value("readdata", exp_q[0], readdata);
               void'(due_q.pop_front());
               void'(exp_q.pop_front());
            end
         end
         // chipselect spans the command, the cycle after a read and reads in flight
         cs_expect = uav.read | uav.write | rd_prev | (due_q.size() != 0);
         if (av.chipselect != cs_expect) begin
            flag_value("chipselect", 32'(cs_expect), 32'(av.chipselect));
         end
         if ((uav.read || uav.write) && av.byteenable != uav.byteenable) begin
            flag_value("byteenable", 32'(uav.byteenable), 32'(av.byteenable));
         end
         rd_prev = uav.read;
         if (uav.read && !waitrequest) begin   // accepted on the coming edge
            due_q.push_back(cyc + rd_latency);
            exp_q.push_back(rd_expect);
         end
      end
   end

   // drive one beat and count cycles until waitrequest drops
   task automatic present_beat(input uav_cmd_t cmd, input int first_bc, output int cycles);
      logic exp_rd;
      logic exp_wr;
      @(posedge clk);
      uav <= cmd;
      cycles = 0;
      do begin
         @(negedge clk);
         cycles++;
         exp_rd = cmd.read && cycles >= strobe_first;
         exp_wr = cmd.write && cycles >= strobe_first && cycles <= wdata_cycle;
         if (av.read != exp_rd) flag_value("read strobe", 32'(exp_rd), 32'(av.read));
         if (av.write != exp_wr) flag_value("write strobe", 32'(exp_wr), 32'(av.write));
         if (cycles == 1 && first_bc > 0 && av.burstcount != av_burst_w'(first_bc))
            flag_value("first beat burstcount", first_bc, 32'(av.burstcount));
      end while (waitrequest && cycles < cycles_per_case);
   endtask

   task automatic run_case(input int i);
      uav_cmd_t cmd;
      int       cycles;
      int       guard;
      int       beats;
      cur_name  = case_name[i];
      beats     = (case_op[i] == "wr") ? case_beats[i] : 1;
      case_errs = 0;
      bt_cnt    = 0;
      bbt_cnt   = 0;
      for (int b = 0; b < beats; b++) begin
         cmd            = '0;
         cmd.address    = case_addr[i] + 32'(4 * b);
         cmd.byteenable = (case_op[i] == "wr") ? case_be[i] : 4'hf;
         cmd.writedata  = case_data[i];
         cmd.burstcount = uav_burst_w'(4 * (beats - b));   // bytes left in the burst
         if (case_op[i] == "wr") begin
            cmd.write = 1'b1;
         end else begin
            cmd.read  = 1'b1;
            rd_expect = mirror_word(int'(case_addr[i] >> 2));
            if (rd_expect != case_exp[i]) begin
               $display("error %s case file value disagrees with the mirror", cur_name);
               case_errs++;
            end
         end
         present_beat(cmd, (b == 0 && cmd.write) ? beats : 0, cycles);
         if (cycles != accept_cycle) flag_value("accept cycle", accept_cycle, cycles);
         if (cmd.write) begin
            mirror[int'(cmd.address >> 2)] =
               merge_bytes(mirror_word(int'(cmd.address >> 2)), cmd.writedata, cmd.byteenable);
         end
      end
      @(posedge clk);
      uav <= '0;
      if (bt_cnt != beats) flag_value("begintransfer count", beats, bt_cnt);
      if (bbt_cnt != 1) flag_value("beginbursttransfer count", 1, bbt_cnt);
      guard = 0;
      while (due_q.size() != 0 && guard < cycles_per_case) begin
         @(posedge clk);
         guard++;
      end
      if (due_q.size() != 0) begin
         $display("error %s read data never returned", cur_name);
         case_errs++;
      end
      if (case_errs == 0) passed++;
      else failed++;
      errors += case_errs;
      $display("%-12s %s", cur_name, (case_errs == 0) ? "pass" : "FAIL");
      repeat ($urandom_range(3, 0)) @(posedge clk);   // idle gap
   endtask

   // watchdog sized from the number of cases
   initial begin
      wait (ncases > 0);
      repeat (ncases * cycles_per_case + 20) @(posedge clk);
      $display("watchdog: the run did not finish in time");
      $display("Done: errors found");
      $finish;
   end

   initial begin
      int          fd;
      int          n;
      string       line;
      string       nm;
      string       op;
      logic [31:0] addr;
      logic [31:0] data;
      logic [31:0] exp;
      logic [3:0]  be;
      int          beats;
      reset   = 1'b1;
      uav     = '0;
      rd_prev = 1'b0;
      errors  = 0;
      passed  = 0;
      failed  = 0;
      void'($urandom(49));
      fd = $fopen("sim/translator_cases.txt", "r");
      if (fd == 0) begin
         $display("could not open the case file");
         errors++;
      end else begin
         while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line[0] != "#") begin
               n = $sscanf(line, "%s %s %h %d %h %h %h", nm, op, addr, beats, data, be, exp);
               if (n == 7) begin
                  case_name.push_back(nm);
                  case_op.push_back(op);
                  case_addr.push_back(addr);
                  case_beats.push_back(beats);
                  case_data.push_back(data);
                  case_be.push_back(be);
                  case_exp.push_back(exp);
               end
            end
         end
         $fclose(fd);
         if (case_name.size() == 0) begin
            $display("the case file holds no cases");
            errors++;
         end
         ncases = case_name.size();
      end
      repeat (10) @(posedge clk);
      reset <= 1'b0;
      repeat (2) @(posedge clk);
      for (int i = 0; i < ncases; i++) begin
         run_case(i);
      end
      $display("cases %0d passed %0d failed %0d errors %0d", ncases, passed, failed, errors);
      if (errors == 0 && failed == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* src.f */
hw/xlat_pkg.sv
hw/wait_state_timer.sv
hw/read_latency_pipe.sv
hw/transfer_markers.sv
hw/command_mapper.sv
hw/slave_translator.sv
sim/target_model.sv
sim/tb_slave_translator.sv

/* run.sh */
#!/usr/bin/env bash
# builds the translator testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing -f src.f --top-module tb_slave_translator -o tb_sim
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit 1
fi

./obj_dir/tb_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "Done: errors found" "$log"; then
   echo "simulation reported failures"
   exit 1
fi

echo "simulation passed"
exit 0

/* sim/translator_cases.txt */
# name op byte_addr beats data byteenable expected  (hex except beats)
# writes carry expected 0, reads carry burst 1, data 0 and byteenable f
w_full_000 wr 000 1 11223344 f 00000000
r_full_000 rd 000 1 00000000 f 11223344
w_lo_000 wr 000 1 aabbccdd 3 00000000
r_lo_000 rd 000 1 00000000 f 1122ccdd
w_hi_004 wr 004 1 deadbeef c 00000000
r_hi_004 rd 004 1 00000000 f dead0000
w_b3_010 wr 010 3 cafef00d f 00000000
r_b3_010 rd 010 1 00000000 f cafef00d
r_b3_014 rd 014 1 00000000 f cafef00d
r_b3_018 rd 018 1 00000000 f cafef00d
w_mid_018 wr 018 1 12345678 6 00000000
r_mid_018 rd 018 1 00000000 f ca34560d
w_b3_020 wr 020 3 01020304 5 00000000
r_b3_028 rd 028 1 00000000 f 00020004
r_b3_024 rd 024 1 00000000 f 00020004
w_b2_040 wr 040 2 a5a5a5a5 9 00000000
r_b2_044 rd 044 1 00000000 f a50000a5
r_zero_080 rd 080 1 00000000 f 00000000
w_b0_080 wr 080 1 ffffffff 1 00000000
r_b0_080 rd 080 1 00000000 f 000000ff
w_b1_100 wr 100 1 87654321 2 00000000
r_b1_102 rd 102 1 00000000 f 00004300
r_rep_000 rd 000 1 00000000 f 1122ccdd
